// File: phivers_pkg.sv
package phivers_pkg;

    // ******************************************************************
    // Sizes
    // ******************************************************************

    localparam int FLIT_W  = 32;  // Flit width.
    localparam int COORD_W = 8;   // One mesh coordinate.
    localparam int N_PORTS = 5;   // Router ports.

    // ******************************************************************
    // Types
    // ******************************************************************

    // Router address with x in the upper byte.
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } node_addr_t;

    typedef struct packed {
        logic [15:0] seq;   // Stamped by the injector.
        node_addr_t  dest;  // Target router.
    } flit_header_t;

    // Head flit reads as hdr and body flits as raw.
    typedef union packed {
        logic [FLIT_W-1:0] raw;
        flit_header_t      hdr;
    } flit_u;

    typedef struct packed {
        logic  tx;    // Flit valid.
        logic  eop;   // Last flit of the packet.
        flit_u data;
    } hermes_link_t;

    typedef enum logic [2:0] {
        EAST  = 3'd0,
        WEST  = 3'd1,
        NORTH = 3'd2,
        SOUTH = 3'd3,
        LOCAL = 3'd4
    } hermes_port_e;

endpackage

// File: hermes_buffer.sv
module hermes_buffer #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  phivers_pkg::hermes_link_t link_i,
    output logic                      credit_o,
    output phivers_pkg::hermes_link_t head_o,
    input  logic                      pop_i
);

    localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

    phivers_pkg::hermes_link_t mem [BUFFER_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign credit_o = (count_q < CNT_W'(BUFFER_DEPTH));  // Room for one more.
    assign push     = link_i.tx && credit_o;
    assign pop      = pop_i && head_o.tx;

    always_comb begin
        head_o    = mem[rd_ptr_q];
        head_o.tx = (count_q != '0);  // Not empty.
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= link_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: hermes_switch_ctrl.sv
module hermes_switch_ctrl #(
    parameter phivers_pkg::node_addr_t ADDRESS = '0
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  phivers_pkg::hermes_link_t            head_i [phivers_pkg::N_PORTS],
    input  logic [phivers_pkg::N_PORTS-1:0]      credit_i,
    output phivers_pkg::hermes_port_e            sel_o [phivers_pkg::N_PORTS],
    output logic [phivers_pkg::N_PORTS-1:0]      out_active_o,
    output logic [phivers_pkg::N_PORTS-1:0]      pop_o
);

    localparam int NP    = phivers_pkg::N_PORTS;
    localparam int SEL_W = $clog2(NP);

    phivers_pkg::hermes_port_e route [NP];
    phivers_pkg::hermes_port_e grant_out;
    logic [NP-1:0]             in_busy_q;
    logic [NP-1:0]             release_out;
    logic [SEL_W-1:0]          rr_ptr_q;
    logic [SEL_W-1:0]          grant_in;
    logic                      grant_valid;

    // X first, then Y.
    function automatic phivers_pkg::hermes_port_e xy_route(input phivers_pkg::node_addr_t dest);
        if (dest.x > ADDRESS.x) begin
            return phivers_pkg::EAST;
        end else if (dest.x < ADDRESS.x) begin
            return phivers_pkg::WEST;
        end else if (dest.y > ADDRESS.y) begin
            return phivers_pkg::NORTH;
        end else if (dest.y < ADDRESS.y) begin
            return phivers_pkg::SOUTH;
        end
        return phivers_pkg::LOCAL;
    endfunction

    // ******************************************************************
    // Routing and round-robin grant
    // ******************************************************************

    always_comb begin
        for (int i = 0; i < NP; i++) begin
            route[i] = xy_route(head_i[i].data.hdr.dest);  // Valid only on a head flit.
        end
    end

    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_in    = '0;
        grant_out   = phivers_pkg::LOCAL;
        for (int k = 0; k < NP; k++) begin
            idx = (int'(rr_ptr_q) + k) % NP;
            if (!grant_valid && head_i[idx].tx && !in_busy_q[idx]
                    && !out_active_o[route[idx]]) begin
                grant_valid = 1'b1;
                grant_in    = SEL_W'(idx);
                grant_out   = route[idx];
            end
        end
    end

    // ******************************************************************
    // Flit forwarding and release on eop
    // ******************************************************************

    always_comb begin
        pop_o       = '0;
        release_out = '0;
        for (int o = 0; o < NP; o++) begin
            if (out_active_o[o] && head_i[sel_o[o]].tx && credit_i[o]) begin
                pop_o[sel_o[o]] = 1'b1;
                release_out[o]  = head_i[sel_o[o]].eop;  // Tail leaves.
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_active_o <= '0;
            in_busy_q    <= '0;
            rr_ptr_q     <= '0;
            for (int o = 0; o < NP; o++) begin
                sel_o[o] <= phivers_pkg::LOCAL;
            end
        end else begin
            for (int o = 0; o < NP; o++) begin
                if (release_out[o]) begin
                    out_active_o[o]     <= 1'b0;
                    in_busy_q[sel_o[o]] <= 1'b0;
                end
            end
            if (grant_valid) begin
                out_active_o[grant_out] <= 1'b1;
                sel_o[grant_out]        <= phivers_pkg::hermes_port_e'(grant_in);
                in_busy_q[grant_in]     <= 1'b1;
                rr_ptr_q <= (grant_in == SEL_W'(NP - 1)) ? '0 : grant_in + 1'b1;
            end
        end
    end

endmodule

// File: hermes_router.sv
module hermes_router #(
    parameter phivers_pkg::node_addr_t ADDRESS      = '0,
    parameter int                      BUFFER_DEPTH = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  phivers_pkg::hermes_link_t        link_i [phivers_pkg::N_PORTS],
    output logic [phivers_pkg::N_PORTS-1:0]  credit_o,
    output phivers_pkg::hermes_link_t        link_o [phivers_pkg::N_PORTS],
    input  logic [phivers_pkg::N_PORTS-1:0]  credit_i
);

    localparam int NP = phivers_pkg::N_PORTS;

    phivers_pkg::hermes_link_t head [NP];
    phivers_pkg::hermes_port_e sel [NP];
    logic [NP-1:0]             out_active;
    logic [NP-1:0]             pop;

    // ******************************************************************
    // Input buffers
    // ******************************************************************

    for (genvar p = 0; p < NP; p++) begin : gen_buf
        hermes_buffer #(
            .BUFFER_DEPTH (BUFFER_DEPTH)
        ) u_buffer (
            .clk_i    (clk_i      ),
            .rst_n_i  (rst_n_i    ),
            .link_i   (link_i[p]  ),
            .credit_o (credit_o[p]),
            .head_o   (head[p]    ),
            .pop_i    (pop[p]     )
        );
    end

    hermes_switch_ctrl #(
        .ADDRESS (ADDRESS)
    ) u_switch_ctrl (
        .clk_i        (clk_i     ),
        .rst_n_i      (rst_n_i   ),
        .head_i       (head      ),
        .credit_i     (credit_i  ),
        .sel_o        (sel       ),
        .out_active_o (out_active),
        .pop_o        (pop       )
    );

    // ******************************************************************
    // Crossbar
    // ******************************************************************

    always_comb begin
        for (int o = 0; o < NP; o++) begin
            if (out_active[o]) begin
                link_o[o] = head[sel[o]];
            end else begin
                link_o[o] = '0;  // Idle output.
            end
        end
    end

endmodule

// File: packet_injector.sv
module packet_injector (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  phivers_pkg::hermes_link_t src_link_i,
    output logic                      src_credit_o,
    output phivers_pkg::hermes_link_t noc_link_o,
    input  logic                      noc_credit_i
);

    logic               out_valid_q;
    logic               out_eop_q;
    phivers_pkg::flit_u out_data_q;
    logic               in_body_q;   // Past the header flit.
    logic [15:0]        seq_q;
    logic               accept;
    phivers_pkg::flit_u stamped;

    // Free slot, or the held flit drains this cycle.
    assign src_credit_o = !out_valid_q || noc_credit_i;
    assign accept       = src_link_i.tx && src_credit_o;

    always_comb begin
        stamped = src_link_i.data;
        if (!in_body_q) begin
            stamped.hdr.seq = seq_q;  // Header gets the sequence number.
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
            in_body_q   <= 1'b0;
            seq_q       <= '0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
            in_body_q   <= !src_link_i.eop;
            if (src_link_i.eop) begin
                seq_q <= seq_q + 1'b1;  // Wraps at 2^16.
            end
        end else if (noc_credit_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_eop_q  <= src_link_i.eop;
            out_data_q <= stamped;
        end
    end

    always_comb begin
        noc_link_o.tx   = out_valid_q;
        noc_link_o.eop  = out_eop_q;
        noc_link_o.data = out_data_q;
    end

endmodule

// File: packet_collector.sv
module packet_collector #(
    parameter int N_PE_X = 2,
    parameter int N_PE_Y = 2
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  phivers_pkg::hermes_link_t   local_link_i [N_PE_X*N_PE_Y],
    output logic [N_PE_X*N_PE_Y-1:0]    local_credit_o,
    output phivers_pkg::hermes_link_t   out_link_o,
    output phivers_pkg::node_addr_t     out_node_o,
    input  logic                        out_credit_i
);

    localparam int N_NODES = N_PE_X * N_PE_Y;
    localparam int IDX_W   = (N_NODES > 1) ? $clog2(N_NODES) : 1;
    localparam int CW      = phivers_pkg::COORD_W;

    logic             locked_q;
    logic [IDX_W-1:0] grant_q;
    logic [IDX_W-1:0] rr_ptr_q;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_valid;

    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int k = 0; k < N_NODES; k++) begin
            idx = (int'(rr_ptr_q) + k) % N_NODES;
            if (!pick_valid && local_link_i[idx].tx) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(idx);
            end
        end
    end

    always_comb begin
        out_link_o     = '0;
        local_credit_o = '0;
        if (locked_q) begin
            out_link_o              = local_link_i[grant_q];
            out_link_o.tx           = local_link_i[grant_q].tx && out_credit_i;  // Held back.
            local_credit_o[grant_q] = out_credit_i;
        end
    end

    // Index is x * N_PE_Y + y.
    assign out_node_o.x = CW'(int'(grant_q) / N_PE_Y);
    assign out_node_o.y = CW'(int'(grant_q) % N_PE_Y);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            locked_q <= 1'b0;
            grant_q  <= '0;
            rr_ptr_q <= '0;
        end else if (!locked_q) begin
            if (pick_valid) begin
                locked_q <= 1'b1;
                grant_q  <= pick_idx;
            end
        end else if (out_link_o.tx && out_link_o.eop) begin
            locked_q <= 1'b0;  // Packet done so the next port gets priority.
            rr_ptr_q <= (grant_q == IDX_W'(N_NODES - 1)) ? '0 : grant_q + 1'b1;
        end
    end

endmodule

// File: phivers_mesh.sv
module phivers_mesh #(
    parameter int N_PE_X       = 2,
    parameter int N_PE_Y       = 2,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  phivers_pkg::hermes_link_t src_link_i,
    output logic                      src_credit_o,
    output phivers_pkg::hermes_link_t out_link_o,
    output phivers_pkg::node_addr_t   out_node_o,
    input  logic                      out_credit_i
);

    localparam int NP = phivers_pkg::N_PORTS;
    localparam int CW = phivers_pkg::COORD_W;

    phivers_pkg::hermes_link_t link_rx [N_PE_X][N_PE_Y][NP];  // Into each router.
    phivers_pkg::hermes_link_t link_tx [N_PE_X][N_PE_Y][NP];  // Out of each router.
    logic [NP-1:0]             credit_rx [N_PE_X][N_PE_Y];
    logic [NP-1:0]             credit_tx [N_PE_X][N_PE_Y];
    phivers_pkg::hermes_link_t inj_link;
    phivers_pkg::hermes_link_t local_link [N_PE_X*N_PE_Y];
    logic [N_PE_X*N_PE_Y-1:0]  local_credit;

    packet_injector u_injector (
        .clk_i        (clk_i                               ),
        .rst_n_i      (rst_n_i                             ),
        .src_link_i   (src_link_i                          ),
        .src_credit_o (src_credit_o                        ),
        .noc_link_o   (inj_link                            ),
        .noc_credit_i (credit_rx[0][0][phivers_pkg::SOUTH] )
    );

    // ******************************************************************
    // Router array
    // ******************************************************************

    for (genvar x = 0; x < N_PE_X; x++) begin : gen_x
        for (genvar y = 0; y < N_PE_Y; y++) begin : gen_y
            localparam phivers_pkg::node_addr_t NODE_ADDR = '{x: CW'(x), y: CW'(y)};

            hermes_router #(
                .ADDRESS      (NODE_ADDR   ),
                .BUFFER_DEPTH (BUFFER_DEPTH)
            ) u_router (
                .clk_i    (clk_i          ),
                .rst_n_i  (rst_n_i        ),
                .link_i   (link_rx[x][y]  ),
                .credit_o (credit_rx[x][y]),
                .link_o   (link_tx[x][y]  ),
                .credit_i (credit_tx[x][y])
            );

            assign local_link[x*N_PE_Y+y] = link_tx[x][y][phivers_pkg::LOCAL];
        end
    end

    packet_collector #(
        .N_PE_X (N_PE_X),
        .N_PE_Y (N_PE_Y)
    ) u_collector (
        .clk_i          (clk_i       ),
        .rst_n_i        (rst_n_i     ),
        .local_link_i   (local_link  ),
        .local_credit_o (local_credit),
        .out_link_o     (out_link_o  ),
        .out_node_o     (out_node_o  ),
        .out_credit_i   (out_credit_i)
    );

    // ******************************************************************
    // Neighbour wiring with idle edges and credit tied high
    // ******************************************************************

    always_comb begin
        for (int x = 0; x < N_PE_X; x++) begin
            for (int y = 0; y < N_PE_Y; y++) begin
                link_rx[x][y][phivers_pkg::EAST] =
                    (x != N_PE_X - 1) ? link_tx[x+1][y][phivers_pkg::WEST] : '0;
                credit_tx[x][y][phivers_pkg::EAST] =
                    (x != N_PE_X - 1) ? credit_rx[x+1][y][phivers_pkg::WEST] : 1'b1;
                link_rx[x][y][phivers_pkg::WEST] =
                    (x != 0) ? link_tx[x-1][y][phivers_pkg::EAST] : '0;
                credit_tx[x][y][phivers_pkg::WEST] =
                    (x != 0) ? credit_rx[x-1][y][phivers_pkg::EAST] : 1'b1;
                link_rx[x][y][phivers_pkg::NORTH] =
                    (y != N_PE_Y - 1) ? link_tx[x][y+1][phivers_pkg::SOUTH] : '0;
                credit_tx[x][y][phivers_pkg::NORTH] =
                    (y != N_PE_Y - 1) ? credit_rx[x][y+1][phivers_pkg::SOUTH] : 1'b1;
                link_rx[x][y][phivers_pkg::SOUTH] =
                    (y != 0) ? link_tx[x][y-1][phivers_pkg::NORTH] : '0;
                credit_tx[x][y][phivers_pkg::SOUTH] =
                    (y != 0) ? credit_rx[x][y-1][phivers_pkg::NORTH] : 1'b1;
                link_rx[x][y][phivers_pkg::LOCAL]   = '0;  // No local source.
                credit_tx[x][y][phivers_pkg::LOCAL] = local_credit[x*N_PE_Y+y];
            end
        end
        link_rx[0][0][phivers_pkg::SOUTH] = inj_link;  // Injector on the south edge.
    end

endmodule

// File: tb_phivers_mesh.sv
module tb_phivers_mesh;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          N_PE_X  = 2;
    localparam int          N_PE_Y  = 2;
    localparam int          TIMEOUT = 200;           // Cycles per wait.
    localparam int          HOLD    = 60;            // Back-pressure cycles.
    localparam logic [31:0] SEED    = 32'hdbcc_6c1a;

    typedef logic [phivers_pkg::FLIT_W-1:0] word_q_t [$];

    logic                      clk_i;
    logic                      rst_n_i;
    phivers_pkg::hermes_link_t src_link_i;
    logic                      src_credit_o;
    phivers_pkg::hermes_link_t out_link_o;
    phivers_pkg::node_addr_t   out_node_o;
    logic                      out_credit_i;

    phivers_pkg::hermes_link_t exp_flits [$];  // Expected flits in send order.
    logic [15:0]               model_seq;
    int                        mismatches;
    int                        failures;

    phivers_mesh #(
        .N_PE_X       (N_PE_X),
        .N_PE_Y       (N_PE_Y),
        .BUFFER_DEPTH (4     )
    ) dut0 (
        .clk_i        (clk_i       ),
        .rst_n_i      (rst_n_i     ),
        .src_link_i   (src_link_i  ),
        .src_credit_o (src_credit_o),
        .out_link_o   (out_link_o  ),
        .out_node_o   (out_node_o  ),
        .out_credit_i (out_credit_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ******************************************************************
    // Helpers
    // ******************************************************************

    // Outputs are stable 1 ns after the falling edge.
    task automatic settle();
        @(negedge clk_i);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("mismatch at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic require(input bit cond, input string what);
        assert (cond) else begin
            failures++;
            $display("error at %0d ns: %s", $time, what);
        end
    endtask

    function automatic phivers_pkg::node_addr_t node_at(input int x, input int y);
        phivers_pkg::node_addr_t addr;
        addr.x = phivers_pkg::COORD_W'(x);
        addr.y = phivers_pkg::COORD_W'(y);
        return addr;
    endfunction

    function automatic word_q_t random_payload(input int len);
        word_q_t words;
        for (int i = 0; i < len; i++) begin
            words.push_back($urandom);
        end
        return words;
    endfunction

    task automatic drive_flit(input phivers_pkg::hermes_link_t flit, output bit accepted);
        int waited;
        waited = 0;
        @(negedge clk_i);
        src_link_i = flit;
        #1;
        while (!src_credit_o && waited < TIMEOUT) begin
            settle();
            waited++;
        end
        accepted = src_credit_o;  // Taken on the coming rising edge.
        require(accepted, "timeout waiting for src_credit_o");
    endtask

    task automatic send_packet(input phivers_pkg::node_addr_t dest, input word_q_t payload);
        phivers_pkg::hermes_link_t pkt [$];
        phivers_pkg::hermes_link_t flit;
        bit                        accepted;
        flit               = '0;
        flit.tx            = 1'b1;
        flit.eop           = (payload.size() == 0);
        flit.data.hdr.dest = dest;
        flit.data.hdr.seq  = model_seq;
        exp_flits.push_back(flit);
        flit.data.hdr.seq  = 16'hdead;  // Injector stamps its own number.
        pkt.push_back(flit);
        foreach (payload[i]) begin
            flit.data.raw = payload[i];
            flit.eop      = (i == payload.size() - 1);
            pkt.push_back(flit);
            exp_flits.push_back(flit);
        end
        model_seq++;
        accepted = 1'b1;
        for (int i = 0; i < pkt.size() && accepted; i++) begin
            drive_flit(pkt[i], accepted);
        end
        @(negedge clk_i);
        src_link_i = '0;
    endtask

    // Entered at a sample point that has not been looked at yet.
    task automatic receive_packet();
        phivers_pkg::hermes_link_t exp;
        phivers_pkg::node_addr_t   dest;
        bit                        first;
        bit                        done;
        int                        waited;
        first = 1'b1;
        done  = 1'b0;
        dest  = '0;
        while (!done) begin
            waited = 0;
            while (!out_link_o.tx && waited < TIMEOUT) begin
                settle();
                waited++;
            end
            require(out_link_o.tx, "timeout waiting for a flit on out_link_o");
            if (!out_link_o.tx) begin
                return;
            end
            require(exp_flits.size() != 0, "flit on out_link_o with no packet outstanding");
            if (exp_flits.size() == 0) begin
                settle();
                return;
            end
            exp = exp_flits.pop_front();
            if (first) begin
                dest = exp.data.hdr.dest;
                check_value("out_link_o.data.hdr.dest", dest, out_link_o.data.hdr.dest);
                check_value("out_link_o.data.hdr.seq", exp.data.hdr.seq,
                            out_link_o.data.hdr.seq);
            end else begin
                check_value("out_link_o.data.raw", exp.data.raw, out_link_o.data.raw);
            end
            check_value("out_node_o", dest, out_node_o);
            check_value("out_link_o.eop", exp.eop, out_link_o.eop);
            first = 1'b0;
            done  = exp.eop;
            settle();
        end
    endtask

    // ******************************************************************
    // Directed tests
    // ******************************************************************

    task automatic reset_idle();
        int waited;
        waited = 0;
        settle();
        check_value("out_link_o.tx", 0, out_link_o.tx);
        while (!src_credit_o && waited < TIMEOUT) begin
            settle();
            waited++;
        end
        require(src_credit_o, "src_credit_o stayed low after reset");
    endtask

    task automatic single_packet();
        word_q_t payload;
        payload = '{32'h1111_aaaa, 32'h2222_bbbb, 32'h3333_cccc};
        fork
            send_packet(node_at(1, 1), payload);
            begin
                settle();
                receive_packet();
            end
        join
    endtask

    task automatic every_node();
        word_q_t payload;
        for (int x = 0; x < N_PE_X; x++) begin
            for (int y = 0; y < N_PE_Y; y++) begin
                payload = random_payload(2);
                fork
                    send_packet(node_at(x, y), payload);
                    begin
                        settle();
                        receive_packet();
                    end
                join
            end
        end
    endtask

    task automatic random_lengths();
        fork
            for (int i = 0; i < 6; i++) begin
                send_packet(node_at(0, 1), random_payload(int'($urandom % 8) + 1));
            end
            begin
                settle();
                for (int i = 0; i < 6; i++) begin
                    receive_packet();
                end
            end
        join
    endtask

    task automatic backpressure();
        @(negedge clk_i);
        out_credit_i = 1'b0;
        fork
            for (int i = 0; i < 5; i++) begin
                send_packet(node_at(1, 1), random_payload(4));
            end
            begin
                for (int c = 0; c < HOLD; c++) begin
                    #1;
                    check_value("out_link_o.tx", 0, out_link_o.tx);
                    @(negedge clk_i);
                end
                check_value("src_credit_o", 0, src_credit_o);  // Path is full.
                out_credit_i = 1'b1;
                #1;
                for (int i = 0; i < 5; i++) begin
                    receive_packet();
                end
            end
        join
    endtask

    initial begin
        void'($urandom(SEED));
        src_link_i   = '0;
        out_credit_i = 1'b1;
        rst_n_i      = 1'b0;
        model_seq    = '0;
        mismatches   = 0;
        failures     = 0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        reset_idle();
        single_packet();
        every_node();
        random_lengths();
        backpressure();
        require(exp_flits.size() == 0, "some sent flits never arrived");

        $display("run complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: phivers_mesh.f
phivers_pkg.sv
hermes_buffer.sv
hermes_switch_ctrl.sv
hermes_router.sv
packet_injector.sv
packet_collector.sv
phivers_mesh.sv
tb_phivers_mesh.sv
